// ==== flist.f ====
+incdir+include
design/glb_pkg.sv
design/glb_wb_cfg_bridge.sv
design/glb_dma_counter.sv
design/glb_intr_ctrl.sv
design/glb_intr_top.sv
test/glb_intr_chk.sv
test/glb_intr_tb.sv

// ==== Makefile ====
TOP := glb_intr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o glb_intr_sim
	./obj_dir/glb_intr_sim | tee sim.log
	@if grep -q "\*\* FAIL \*\*" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "\*\* PASS \*\*" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== test/glb_intr_tb.sv ====
// testbench for the interrupt path, wishbone tasks and register model
// directed tests, random mix, per-test report, watchdog
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_intr_tb;

    localparam int AW = `GLB_ADDR_W;
    localparam int DW = `GLB_DATA_W;
    localparam int NC = `GLB_NUM_CHAN;
    localparam int PERIOD = 100;
    // longest length ever loaded, settle must outlast it
    localparam int MAX_LEN = 48;
    localparam int SETTLE = MAX_LEN + 4;
    localparam int ACK_LIMIT = 16;
    localparam int MIX_ROUNDS = 24;
    localparam int NUM_TESTS = 6;
    // random mix is longest, up to 7 bus cycles plus settle per round
    localparam int TEST_CYCLES = MIX_ROUNDS * (7 * ACK_LIMIT + SETTLE);
    localparam logic [AW-1:0] IER = AW'(`GLB_ADDR_IER);
    localparam logic [AW-1:0] ISR = AW'(`GLB_ADDR_ISR);
    localparam logic [DW-1:0] CHAN_MASK = DW'({NC{1'b1}});

    logic          clk;
    logic          reset;
    logic          cyc;
    logic          stb;
    logic          we;
    logic [AW-1:0] adr;
    logic [DW-1:0] dat_w;
    logic [DW-1:0] dat_r;
    logic          ack;
    logic          interrupt;
    // reference model
    logic [NC-1:0] model_ier;
    logic [NC-1:0] model_isr;
    int            model_cnt [NC];
    int            fail_cnt;
    int            errs_at_start;
    int            tests_ok;
    int            tests_bad;

    glb_intr_top DUT (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .interrupt (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * TEST_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_equal(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            fail_cnt++;
        end
    endtask

    // one classic cycle, stb held through the ack edge
    task automatic bus_cycle(input logic write, input logic [AW-1:0] addr,
                             input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = addr;
        dat_w = wdata;
        @(negedge clk);
        while (!ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            rdata = dat_r;
        end else begin
            $display("no ack from DUT for address 0x%0h", addr);
            fail_cnt++;
        end
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_reg(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        logic [DW-1:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic write_ier(input logic [DW-1:0] data);
        write_reg(IER, data);
        model_ier = data[NC-1:0];
    endtask

    // toggle write, only while all counters idle
    task automatic write_isr(input logic [DW-1:0] data);
        write_reg(ISR, data);
        model_isr = model_isr ^ data[NC-1:0];
    endtask

    task automatic load_len(input int c, input int len);
        write_reg(AW'(`GLB_ADDR_LEN_BASE + 4 * c), DW'(len));
        model_cnt[c] = len;
    endtask

    // every nonzero load completes, enabled ones set status
    task automatic settle();
        repeat (SETTLE) @(negedge clk);
        for (int c = 0; c < NC; c++) begin
            if (model_cnt[c] != 0 && model_ier[c]) begin
                model_isr[c] = 1'b1;
            end
            model_cnt[c] = 0;
        end
    endtask

    task automatic finish_test(input string name);
        if (fail_cnt == errs_at_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, fail_cnt - errs_at_start);
        end
        errs_at_start = fail_cnt;
    endtask

    initial begin
        logic [DW-1:0] rd_val;
        logic [DW-1:0] pair;
        int            c;
        int            d;
        void'($urandom(60));
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        model_ier = '0;
        model_isr = '0;
        foreach (model_cnt[i]) model_cnt[i] = 0;
        fail_cnt = 0;
        errs_at_start = 0;
        tests_ok = 0;
        tests_bad = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // enable register masking, unmapped hole
        rd_val = $urandom;
        write_ier(rd_val);
        pair = rd_val & CHAN_MASK;
        read_reg(IER, rd_val);
        check_equal("ier_readback", pair, rd_val);
        read_reg(AW'('h08), rd_val);
        check_equal("unmapped_zero", '0, rd_val);
        finish_test("ier_readback");

        // all enabled, one channel completes
        write_ier(CHAN_MASK);
        c = $urandom_range(NC - 1, 0);
        load_len(c, $urandom_range(MAX_LEN, 1));
        settle();
        read_reg(ISR, rd_val);
        check_equal("enabled_done_isr", DW'(1) << c, rd_val);
        check_equal("enabled_done_irq", DW'(1), DW'(interrupt));
        finish_test("enabled_done");

        // clear status, then complete on a disabled channel
        write_isr(DW'(model_isr));
        c = $urandom_range(NC - 1, 0);
        write_ier(CHAN_MASK & ~(DW'(1) << c));
        load_len(c, $urandom_range(MAX_LEN, 1));
        settle();
        read_reg(ISR, rd_val);
        check_equal("masked_done_isr", '0, rd_val);
        check_equal("masked_done_irq", '0, DW'(interrupt));
        finish_test("masked_done");

        // two distinct channels, clear both, then set one back
        write_ier(CHAN_MASK);
        c = $urandom_range(NC - 1, 0);
        d = (c + 1 + $urandom_range(NC - 2, 0)) % NC;
        pair = (DW'(1) << c) | (DW'(1) << d);
        load_len(c, $urandom_range(MAX_LEN, 1));
        load_len(d, $urandom_range(MAX_LEN, 1));
        settle();
        read_reg(ISR, rd_val);
        check_equal("toggle_both_set", pair, rd_val);
        write_isr(pair);
        read_reg(ISR, rd_val);
        check_equal("toggle_cleared", '0, rd_val);
        check_equal("toggle_irq_low", '0, DW'(interrupt));
        write_isr(DW'(1) << c);
        read_reg(ISR, rd_val);
        check_equal("toggle_set", DW'(1) << c, rd_val);
        check_equal("toggle_irq_high", DW'(1), DW'(interrupt));
        finish_test("toggle_clear");

        // remaining count while busy, zero when done
        c = $urandom_range(NC - 1, 0);
        load_len(c, MAX_LEN);
        read_reg(AW'(`GLB_ADDR_LEN_BASE + 4 * c), rd_val);
        check_equal("len_busy_range", DW'(1), DW'(rd_val != 0 && rd_val <= DW'(MAX_LEN)));
        settle();
        read_reg(AW'(`GLB_ADDR_LEN_BASE + 4 * c), rd_val);
        check_equal("len_done_zero", '0, rd_val);
        finish_test("len_readback");

        // random rounds, enable and toggle first while counters idle
        for (int r = 0; r < MIX_ROUNDS; r++) begin
            write_ier($urandom);
            write_isr($urandom);
            d = $urandom_range(4, 1);
            for (int k = 0; k < d; k++) begin
                load_len($urandom_range(NC - 1, 0), $urandom_range(MAX_LEN, 1));
            end
            settle();
            read_reg(ISR, rd_val);
            check_equal("random_mix_isr", DW'(model_isr), rd_val);
            check_equal("random_mix_irq", DW'(model_isr != '0), DW'(interrupt));
        end
        finish_test("random_mix");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== test/glb_intr_chk.sv ====
// bus handshake and interrupt line assertions
// bound into the interrupt path top level
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_intr_chk (
    input logic                     clk,
    input logic                     reset,
    input logic                     cyc,
    input logic                     stb,
    input logic                     ack,
    input logic                     interrupt,
    input logic [`GLB_NUM_CHAN-1:0] isr
);

    // ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // level interrupt follows pending status
    intr_is_isr_or: assert property (@(posedge clk) disable iff (reset) interrupt == (|isr))
        else $error("interrupt differs from OR of ISR");

endmodule

bind glb_intr_top glb_intr_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .ack       (ack),
    .interrupt (interrupt),
    .isr       (u_ctrl.isr)
);

// ==== design/glb_intr_top.sv ====
// interrupt path top level
// wishbone bridge, interrupt controller, one counter per dma channel
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_intr_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`GLB_ADDR_W-1:0] adr,
    input  logic [`GLB_DATA_W-1:0] dat_w,
    output logic [`GLB_DATA_W-1:0] dat_r,
    output logic                   ack,
    output logic                   interrupt
);

    // request fans out to controller and every counter
    glb_pkg::cfg_req_t                        cfg_req;
    glb_pkg::cfg_rsp_t                        ctrl_rsp;
    logic [`GLB_NUM_CHAN-1:0][`GLB_DATA_W-1:0] chan_rd_data;
    // one done bit per channel
    logic [`GLB_NUM_CHAN-1:0]                 done_pulses;

    glb_wb_cfg_bridge u_bridge (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .cfg_req      (cfg_req),
        .ctrl_rsp     (ctrl_rsp),
        .chan_rd_data (chan_rd_data)
    );

    glb_intr_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cfg_req     (cfg_req),
        .done_pulses (done_pulses),
        .cfg_rsp     (ctrl_rsp),
        .interrupt   (interrupt)
    );

    // even channel store, odd channel load
    for (genvar c = 0; c < `GLB_NUM_CHAN; c++) begin : gen_chan
        glb_dma_counter #(
            .CHAN_ID (c)
        ) u_cnt (
            .clk        (clk),
            .reset      (reset),
            .cfg_req    (cfg_req),
            .rd_data    (chan_rd_data[c]),
            .done_pulse (done_pulses[c])
        );
    end

endmodule

// ==== design/glb_intr_ctrl.sv ====
// interrupt controller for the global buffer dma channels
// IER and ISR registers, interrupt line, register read-back
// bit 2t is the store channel of tile t, bit 2t+1 its load channel
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_intr_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_pkg::cfg_req_t        cfg_req,
    input  logic [`GLB_NUM_CHAN-1:0] done_pulses,
    output glb_pkg::cfg_rsp_t        cfg_rsp,
    output logic                     interrupt
);

    localparam int AW = `GLB_ADDR_W;
    localparam int DW = `GLB_DATA_W;
    localparam int NC = `GLB_NUM_CHAN;
    localparam int IER_ADDR_I = `GLB_ADDR_IER;
    localparam int ISR_ADDR_I = `GLB_ADDR_ISR;
    localparam logic [AW-1:0] IER_ADDR = IER_ADDR_I[AW-1:0];
    localparam logic [AW-1:0] ISR_ADDR = ISR_ADDR_I[AW-1:0];

    logic [NC-1:0] ier;
    logic [NC-1:0] isr;
    logic          ier_wr;
    logic          isr_wr;

    assign ier_wr = cfg_req.wr_en && (cfg_req.addr == IER_ADDR);
    assign isr_wr = cfg_req.wr_en && (cfg_req.addr == ISR_ADDR);

    // enable register, upper data bits dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ier <= '0;
        end else if (ier_wr) begin
            ier <= cfg_req.wr_data[NC-1:0];
        end
    end

    // status register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isr <= '0;
        end else begin
            for (int i = 0; i < NC; i++) begin
                // enabled completion beats a same-cycle toggle
                if (ier[i] && done_pulses[i]) begin
                    isr[i] <= 1'b1;
                end else if (isr_wr) begin
                    // written ones flip the bit
                    isr[i] <= isr[i] ^ cfg_req.wr_data[i];
                end
            end
        end
    end

    // level interrupt, any pending status
    assign interrupt = |isr;

    // read-back one cycle after rd_en
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rsp <= '0;
        end else begin
            cfg_rsp.rd_data_valid <= cfg_req.rd_en;
            if (cfg_req.rd_en) begin
                case (cfg_req.addr)
                    IER_ADDR: cfg_rsp.rd_data <= DW'(ier);
                    ISR_ADDR: cfg_rsp.rd_data <= DW'(isr);
                    // length registers and holes answer zero here
                    default:  cfg_rsp.rd_data <= '0;
                endcase
            end
        end
    end

endmodule

// ==== design/glb_dma_counter.sv ====
// dma completion counter standing in for one channel
// length register with per-cycle decrement, done pulse and read-back
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_dma_counter #(
    parameter int CHAN_ID = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  glb_pkg::cfg_req_t      cfg_req,
    output logic [`GLB_DATA_W-1:0] rd_data,
    output logic                   done_pulse
);

    localparam int AW = `GLB_ADDR_W;
    localparam int DW = `GLB_DATA_W;
    localparam int CW = `GLB_CNT_W;
    // own length register address
    localparam int LEN_ADDR_I = `GLB_ADDR_LEN_BASE + 4 * CHAN_ID;
    localparam logic [AW-1:0] LEN_ADDR = LEN_ADDR_I[AW-1:0];

    // remaining words
    logic [CW-1:0] count;
    logic          wr_hit;
    logic          rd_hit;

    assign wr_hit = cfg_req.wr_en && (cfg_req.addr == LEN_ADDR);
    assign rd_hit = cfg_req.rd_en && (cfg_req.addr == LEN_ADDR);

    // write loads or reloads, zero cancels
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (wr_hit) begin
            count <= cfg_req.wr_data[CW-1:0];
        end else if (count != '0) begin
            // one word per cycle
            count <= count - CW'(1);
        end
    end

    // last word, unless a write replaces the count this cycle
    assign done_pulse = (count == CW'(1)) && !wr_hit;

    // read data stays zero unless this channel is addressed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_hit) begin
            rd_data <= DW'(count);
        end else begin
            rd_data <= '0;
        end
    end

endmodule

// ==== design/glb_wb_cfg_bridge.sv ====
// wishbone classic slave to configuration request bridge
// one transaction at a time, read data merged from controller and counters
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_wb_cfg_bridge (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       cyc,
    input  logic                                       stb,
    input  logic                                       we,
    input  logic [`GLB_ADDR_W-1:0]                     adr,
    input  logic [`GLB_DATA_W-1:0]                     dat_w,
    output logic [`GLB_DATA_W-1:0]                     dat_r,
    output logic                                       ack,
    output glb_pkg::cfg_req_t                          cfg_req,
    input  glb_pkg::cfg_rsp_t                          ctrl_rsp,
    input  logic [`GLB_NUM_CHAN-1:0][`GLB_DATA_W-1:0]  chan_rd_data
);

    glb_pkg::bridge_state_t state;
    // set after ack, cleared once stb seen low
    logic                   wait_release;
    logic [`GLB_DATA_W-1:0] merged_rd;

    // unowned addresses return zero, so a plain OR selects the owner
    always_comb begin
        merged_rd = ctrl_rsp.rd_data;
        for (int c = 0; c < `GLB_NUM_CHAN; c++) begin
            merged_rd = merged_rd | chan_rd_data[c];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= glb_pkg::st_idle;
            wait_release <= 1'b0;
            cfg_req      <= '0;
            dat_r        <= '0;
        end else begin
            // enables are single-cycle pulses
            cfg_req.wr_en <= 1'b0;
            cfg_req.rd_en <= 1'b0;
            case (state)
                glb_pkg::st_idle: begin
                    if (!stb) begin
                        wait_release <= 1'b0;
                    end
                    if (cyc && stb && !wait_release) begin
                        cfg_req.addr    <= adr;
                        cfg_req.wr_data <= dat_w;
                        if (we) begin
                            // register updates at the end of the ack cycle
                            cfg_req.wr_en <= 1'b1;
                            state         <= glb_pkg::st_ack;
                        end else begin
                            cfg_req.rd_en <= 1'b1;
                            state         <= glb_pkg::st_read_wait;
                        end
                    end
                end
                glb_pkg::st_read_wait: begin
                    // controller valid marks the merge point
                    if (ctrl_rsp.rd_data_valid) begin
                        dat_r <= merged_rd;
                        state <= glb_pkg::st_ack;
                    end
                end
                glb_pkg::st_ack: begin
                    wait_release <= 1'b1;
                    state        <= glb_pkg::st_idle;
                end
                default: begin
                    state <= glb_pkg::st_idle;
                end
            endcase
        end
    end

    // one-cycle ack
    assign ack = (state == glb_pkg::st_ack);

endmodule

// ==== design/glb_pkg.sv ====
// shared types for the interrupt path
// configuration request and read response structs
// bridge FSM state encoding
`include "glb_settings.svh"

package glb_pkg;

    // single-cycle request from the bus bridge
    // at most one of wr_en / rd_en high
    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        logic [`GLB_ADDR_W-1:0] addr;
        logic [`GLB_DATA_W-1:0] wr_data;
    } cfg_req_t;

    // read response, valid one cycle after rd_en
    typedef struct packed {
        logic                   rd_data_valid;
        logic [`GLB_DATA_W-1:0] rd_data;
    } cfg_rsp_t;

    // bridge states
    // st_read_wait covers the rd_en cycle and the response cycle
    typedef enum logic [1:0] {
        st_idle,
        st_read_wait,
        st_ack
    } bridge_state_t;

endpackage

// ==== include/glb_settings.svh ====
// global buffer interrupt path settings
// tile and channel counts, bus and counter widths, register map
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// two dma channels per tile, store then load
`define GLB_NUM_TILES 4
`define GLB_NUM_CHAN (2 * `GLB_NUM_TILES)

// bus widths, data must cover one bit per channel
`define GLB_ADDR_W 8
`define GLB_DATA_W 32

// dma length counter width
`define GLB_CNT_W 16

// register map, length of channel c at base + 4*c
`define GLB_ADDR_IER 'h00
`define GLB_ADDR_ISR 'h04
`define GLB_ADDR_LEN_BASE 'h10

`endif
